//--- common/seg_pkg.sv
// shared types for the scrolling hex display driver
// segment patterns are active low, bit 6 is segment a down to bit 0 as segment g
package seg_pkg;

	typedef logic [3:0] hex_nibble_t;   // one stored hex digit
	typedef logic [6:0] seg_pattern_t;  // a..g, low lights the segment

	// one phase per dot tick, gap keeps the digit dark while the next one is fetched
	typedef enum logic [2:0] {
		PH_A,
		PH_B,
		PH_C,
		PH_D,
		PH_E,
		PH_F,
		PH_G,
		PH_GAP
	} seg_phase_t;

	localparam seg_pattern_t SEG_DARK = 7'b1111111; // all segments off

	// hex to seven segment, common anode table
	function automatic seg_pattern_t hex_to_seg(input hex_nibble_t n);
		seg_pattern_t p;
		case (n)
			4'h0:    p = 7'b0000001; // g off
			4'h1:    p = 7'b1001111; // b c
			4'h2:    p = 7'b0010010;
			4'h3:    p = 7'b0000110;
			4'h4:    p = 7'b1001100;
			4'h5:    p = 7'b0100100;
			4'h6:    p = 7'b0100000;
			4'h7:    p = 7'b0001111; // a b c
			4'h8:    p = 7'b0000000; // everything lit
			4'h9:    p = 7'b0000100;
			4'ha:    p = 7'b0001000;
			4'hb:    p = 7'b1100000; // lower case b
			4'hc:    p = 7'b1110010; // lower case c
			4'hd:    p = 7'b1000010; // lower case d
			4'he:    p = 7'b0110000;
			default: p = 7'b0111000; // F, a e f g
		endcase
		return p;
	endfunction

endpackage

//--- common/scan_if.sv
// request and answer between the digit scan and the segment strobe
// digit_req is a one cycle strobe, pattern_valid follows exactly one cycle later
`timescale 1ns/1ps

interface scan_if #(
	parameter int NUM_DIGITS = 4
);
	import seg_pkg::*;

	localparam int IDX_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

	logic             digit_req;     // strobe asks for the next digit
	logic [IDX_W-1:0] digit_index;   // digit now on the anodes
	seg_pattern_t     pattern;       // decoded pattern of that digit
	logic             pattern_valid; // pattern is fresh this cycle

	modport scan (
		input  digit_req,
		output digit_index,
		output pattern,
		output pattern_valid
	);

	modport strobe (
		output digit_req,
		input  pattern,
		input  pattern_valid
	);

endinterface

//--- verilog/tick_gen.sv
// prescaler for the dot tick and the auto step tick
// both divisors must be at least 2, first tick comes DIV cycles after reset
`timescale 1ns/1ps

module tick_gen #(
	parameter int DOT_DIV  = 4096,
	parameter int STEP_DIV = 1 << 24
) (
	input  logic CLK,
	input  logic reset,
	output logic dot_tick,
	output logic step_tick
);

	localparam int MAX_DIV = (DOT_DIV > STEP_DIV) ? DOT_DIV : STEP_DIV;
	localparam int CNT_W   = (MAX_DIV > 2) ? $clog2(MAX_DIV) : 1;

	logic [1:0] tick; // 0 dot, 1 step

	// same down counter twice, only the divisor differs
	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int DIV = (i == 0) ? DOT_DIV : STEP_DIV;

		logic [CNT_W-1:0] cnt;

		always_ff @(posedge CLK) begin
			if (reset) begin
				cnt     <= CNT_W'(DIV - 1); // restart full period
				tick[i] <= 1'b0;
			end else begin
				tick[i] <= (cnt == '0);     // one cycle strobe on wrap
				if (cnt == '0) begin
					cnt <= CNT_W'(DIV - 1);
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	assign dot_tick  = tick[0];
	assign step_tick = tick[1];

endmodule

//--- scroll/digit_shift.sv
// scrolling store of hex digits, new digit enters at index 0 (rightmost)
// push wins over an auto step in the same cycle, steps only count in auto mode
`timescale 1ns/1ps

module digit_shift #(
	parameter int NUM_DIGITS = 4
) (
	input  logic                                    CLK,
	input  logic                                    reset,
	input  logic                                    push,
	input  seg_pkg::hex_nibble_t                    nibble,
	input  logic                                    auto_mode,
	input  logic                                    step_tick,
	output seg_pkg::hex_nibble_t [NUM_DIGITS-1:0]   digits
);
	import seg_pkg::*;

	hex_nibble_t auto_cnt; // counter feeding auto entries
	logic        step_ok;  // step accepted this cycle
	logic        entry;    // something shifts in
	hex_nibble_t new_val;  // value entering digit 0

	always_comb begin
		step_ok = step_tick & auto_mode & ~push; // push has priority
		entry   = push | step_ok;
		new_val = push ? nibble : auto_cnt;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			auto_cnt <= '0;
		end else if (step_ok) begin
			auto_cnt <= auto_cnt + 1'b1; // wraps mod 16
		end
	end

	// older digits move one place left on every entry
	always_ff @(posedge CLK) begin
		if (reset) begin
			digits <= '0;
		end else if (entry) begin
			for (int i = NUM_DIGITS - 1; i > 0; i--) begin
				digits[i] <= digits[i-1];
			end
			digits[0] <= new_val;
		end
	end

endmodule

//--- scan/digit_scan.sv
// digit scan, one anode at a time, active high
// answers each digit_req one cycle later with the decoded pattern of the new digit
`timescale 1ns/1ps

module digit_scan #(
	parameter int NUM_DIGITS = 4
) (
	input  logic                                  CLK,
	input  logic                                  reset,
	input  seg_pkg::hex_nibble_t [NUM_DIGITS-1:0] digits,
	scan_if.scan                                  scan,
	output logic [NUM_DIGITS-1:0]                 anode
);
	import seg_pkg::*;

	localparam int IDX_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_DIGITS - 1);

	logic [IDX_W-1:0] next_idx; // digit selected by the next request

	always_comb begin
		if (scan.digit_index == LAST_IDX) begin
			next_idx = '0; // wrap back to rightmost digit
		end else begin
			next_idx = scan.digit_index + 1'b1;
		end
	end

	// index and anode move together, index parks on the last digit after reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			scan.digit_index <= LAST_IDX;
			anode            <= '0;   // display dark until the first request
		end else if (scan.digit_req) begin
			scan.digit_index <= next_idx;
			anode            <= NUM_DIGITS'(1) << next_idx; // one hot
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			scan.pattern_valid <= 1'b0;
		end else begin
			scan.pattern_valid <= scan.digit_req; // fixed one cycle answer
		end
	end

	// decode once here, the store keeps nibbles
	always_ff @(posedge CLK) begin
		if (scan.digit_req) begin
			scan.pattern <= hex_to_seg(digits[next_idx]);
		end
	end

endmodule

//--- scan/seg_strobe.sv
// segment strobe, lights a through g one per dot tick then a dark gap
// dot ticks must be at least 2 cycles apart so a request is answered before the next tick
`timescale 1ns/1ps

module seg_strobe (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  dot_tick,
	scan_if.strobe                scan,
	output seg_pkg::seg_pattern_t seg
);
	import seg_pkg::*;

	seg_phase_t   phase;   // current segment slot
	seg_pattern_t pat_q;   // pattern of the digit on the anodes
	logic [2:0]   seg_bit; // bit of seg owned by this phase

	// walk a..g on dot ticks, the gap waits for the next pattern
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= PH_GAP; // first request fetches digit 0
		end else if (scan.pattern_valid) begin
			phase <= PH_A;   // new digit starts at segment a
		end else if (dot_tick && phase != PH_GAP) begin
			phase <= seg_phase_t'(phase + 1'b1); // PH_G rolls into PH_GAP
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			scan.digit_req <= 1'b0;
		end else begin
			scan.digit_req <= dot_tick && phase == PH_GAP && !scan.pattern_valid; // single pulse
		end
	end

	always_ff @(posedge CLK) begin
		if (scan.pattern_valid) begin
			pat_q <= scan.pattern;
		end
	end

	// only the segment of this phase may go low, the one before is cleared with it
	always_comb begin
		seg_bit = 3'd6 - 3'(phase); // PH_A owns bit 6
		seg     = SEG_DARK;
		if (phase != PH_GAP) begin
			seg[seg_bit] = pat_q[seg_bit];
		end
	end

endmodule

//--- verilog/seg_scroll_top.sv
// scrolling hex display driver for a common anode seven segment display
// a pushed digit shows once digit 0 is next scanned, within one frame plus one digit
`timescale 1ns/1ps

module seg_scroll_top #(
	parameter int NUM_DIGITS = 4,
	parameter int DOT_DIV    = 4096,   // CLK cycles per segment slot
	parameter int STEP_DIV   = 1 << 24 // CLK cycles per auto step
) (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  push,
	input  logic [3:0]            nibble,
	input  logic                  auto_mode,
	output logic [NUM_DIGITS-1:0] anode,
	output logic [6:0]            seg
);
	import seg_pkg::*;

	logic                         dot_tick;  // one segment slot
	logic                         step_tick; // auto counter step
	hex_nibble_t [NUM_DIGITS-1:0] digits;    // stored digits, 0 is rightmost

	scan_if #(.NUM_DIGITS(NUM_DIGITS)) scan_bus ();

	tick_gen #(
		.DOT_DIV  (DOT_DIV),
		.STEP_DIV (STEP_DIV)
	) u_tick (
		.CLK       (CLK),
		.reset     (reset),
		.dot_tick  (dot_tick),
		.step_tick (step_tick)
	);

	digit_shift #(.NUM_DIGITS(NUM_DIGITS)) u_shift (
		.CLK       (CLK),
		.reset     (reset),
		.push      (push),
		.nibble    (nibble),
		.auto_mode (auto_mode),
		.step_tick (step_tick),
		.digits    (digits)
	);

	digit_scan #(.NUM_DIGITS(NUM_DIGITS)) u_scan (
		.CLK    (CLK),
		.reset  (reset),
		.digits (digits),
		.scan   (scan_bus.scan),
		.anode  (anode)
	);

	seg_strobe u_strobe (
		.CLK      (CLK),
		.reset    (reset),
		.dot_tick (dot_tick),
		.scan     (scan_bus.strobe),
		.seg      (seg)
	);

endmodule

//--- test/seg_scroll_props.sv
// concurrent checks on the scan outputs and the digit request handshake
// bound into seg_scroll_top, idle while reset is high
`timescale 1ns/1ps

module seg_scroll_props #(
	parameter int NUM_DIGITS = 4
) (
	input logic                  CLK,
	input logic                  reset,
	input logic [NUM_DIGITS-1:0] anode,
	input logic [6:0]            seg,
	input logic                  digit_req,
	input logic                  pattern_valid
);

	// one digit at most on the anodes
	a_anode_onehot: assert property (@(posedge CLK) disable iff (reset) $onehot0(anode))
		else $error("anode %h is not one hot", anode);

	// segment at a time, current limit
	a_one_segment: assert property (@(posedge CLK) disable iff (reset) $countones(~seg) <= 1)
		else $error("seg %h has more than one segment low", seg);

	// fixed one cycle answer
	a_req_answer: assert property (@(posedge CLK) disable iff (reset) digit_req |=> pattern_valid)
		else $error("digit_req not answered by pattern_valid");

endmodule

bind seg_scroll_top seg_scroll_props #(
	.NUM_DIGITS (NUM_DIGITS)
) u_props (
	.CLK           (CLK),
	.reset         (reset),
	.anode         (anode),
	.seg           (seg),
	.digit_req     (scan_bus.digit_req),
	.pattern_valid (scan_bus.pattern_valid)
);

//--- test/seg_scroll_tb.sv
// testbench for the scrolling hex display driver, small divisors keep the run short
// display checked through frame composites, the AND of seg per anode over one frame
`timescale 1ns/1ps

module seg_scroll_tb;

	localparam int NUM_DIGITS = 4;
	localparam int DOT_DIV    = 4;
	localparam int STEP_DIV   = 1024;
	localparam int RESET_CYC  = 16;
	localparam int FRAME_CYC  = NUM_DIGITS * 8 * DOT_DIV; // one scan over all digits
	localparam int ROWS       = 16;
	localparam int AUTO_STEPS = 18;                       // enough to wrap the counter
	localparam int LIMIT      = RESET_CYC + (ROWS + AUTO_STEPS + 1) * 3 * FRAME_CYC
		+ (AUTO_STEPS + 2) * STEP_DIV;                // auto entries wait a step each
	localparam logic [NUM_DIGITS-1:0] FIRST_AN = 1;       // anode of digit 0

	// pushed nibble, then digits 3..0 expected after the push
	localparam logic [19:0] PUSH_TABLE [ROWS] = '{
		20'h1_0001, 20'h2_0012, 20'h3_0123, 20'h4_1234,
		20'ha_234a, 20'hb_34ab, 20'hc_4abc, 20'hf_abcf,
		20'h0_bcf0, 20'h8_cf08, 20'h5_f085, 20'he_085e,
		20'h6_85e6, 20'h7_5e67, 20'h9_e679, 20'hd_679d
	};

	// lit segments per hex value, a in bit 6, 1 means lit
	localparam logic [6:0] LIT_MASK [16] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, // 0 1 2 3
		7'h33, 7'h5b, 7'h5f, 7'h70, // 4 5 6 7
		7'h7f, 7'h7b, 7'h77, 7'h1f, // 8 9 A b
		7'h0d, 7'h3d, 7'h4f, 7'h47  // c d E F
	};

	logic                  CLK;
	logic                  reset;
	logic                  push;
	logic [3:0]            nibble;
	logic                  auto_mode;
	logic [NUM_DIGITS-1:0] anode;
	logic [6:0]            seg;

	logic [6:0]  comp [NUM_DIGITS]; // composite of seg per digit
	logic [15:0] exp_disp;          // expected digits, digit 3 on top
	logic [3:0]  auto_val;          // expected auto counter
	int          value_errs;
	int          scan_errs;
	int          cycle_cnt;
	int          gap;

	initial CLK = 1'b0;
	always #50 CLK = ~CLK; // 100 ns period

	seg_scroll_top #(
		.NUM_DIGITS (NUM_DIGITS),
		.DOT_DIV    (DOT_DIV),
		.STEP_DIV   (STEP_DIV)
	) u_dut (
		.CLK       (CLK),
		.reset     (reset),
		.push      (push),
		.nibble    (nibble),
		.auto_mode (auto_mode),
		.anode     (anode),
		.seg       (seg)
	);

	function automatic logic [6:0] expected_seg(input logic [3:0] n);
		return ~LIT_MASK[n]; // active low on the pins
	endfunction

	task automatic check_dark(input string when_txt);
		if (anode !== '0) begin
			$display("ERR anode %s: got %h expected %h", when_txt, anode, {NUM_DIGITS{1'b0}});
			value_errs++;
		end
		if (seg !== 7'h7f) begin
			$display("ERR seg %s: got %h expected %h", when_txt, seg, 7'h7f);
			value_errs++;
		end
	endtask

	// one segment at most, anode walks 0 1 2 3 0
	task automatic check_scan(input logic [NUM_DIGITS-1:0] prev_an);
		logic [NUM_DIGITS-1:0] next_an;
		next_an = (prev_an == '0) ? FIRST_AN : {prev_an[NUM_DIGITS-2:0], prev_an[NUM_DIGITS-1]};
		if ($countones(~seg) > 1) begin
			$display("ERR seg: got %h, more than one segment low", seg);
			scan_errs++;
		end
		if (anode !== prev_an && anode !== next_an) begin
			$display("ERR anode: got %h expected %h", anode, next_an);
			scan_errs++;
		end
	endtask

	// waits for a switch to digit 0, then ANDs seg per anode until the next one
	task automatic capture_frame();
		logic [NUM_DIGITS-1:0] prev_an;
		logic                  done;
		prev_an = anode;
		@(negedge CLK);
		while (!(anode == FIRST_AN && prev_an != FIRST_AN)) begin
			prev_an = anode;
			@(negedge CLK);
		end
		for (int i = 0; i < NUM_DIGITS; i++) begin
			comp[i] = 7'h7f;
		end
		done = 1'b0;
		while (!done) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (anode[i]) begin
					comp[i] = comp[i] & seg;
				end
			end
			prev_an = anode;
			@(negedge CLK);
			check_scan(prev_an);
			if (anode == FIRST_AN && prev_an != FIRST_AN) begin
				done = 1'b1; // frame wrapped
			end
		end
	endtask

	task automatic compare_frame(input logic [15:0] want);
		logic [6:0] exp_pat;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			exp_pat = expected_seg(want[4*i +: 4]);
			if (comp[i] !== exp_pat) begin
				$display("ERR seg digit %0d: got %h expected %h (value %h)",
					i, comp[i], exp_pat, want[4*i +: 4]);
				value_errs++;
			end
		end
	endtask

	// called on a falling edge, returns one falling edge later
	task automatic push_digit(input logic [3:0] val);
		push   = 1'b1;
		nibble = val;
		@(negedge CLK);
		push   = 1'b0;
	endtask

	// returns on the falling edge where the step tick is high
	task automatic wait_step();
		@(negedge CLK);
		while (u_dut.step_tick !== 1'b1) begin
			@(negedge CLK);
		end
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT) begin
			@(posedge CLK);
			cycle_cnt++;
		end
		$display("timeout, run did not finish within %0d cycles", LIMIT);
		$display("errors: %0d value, %0d scan", value_errs, scan_errs);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(27210)); // one seed for the gap picks
		value_errs = 0;
		scan_errs  = 0;
		reset      = 1'b1;
		push       = 1'b0;
		nibble     = 4'h0;
		auto_mode  = 1'b0;
		exp_disp   = 16'h0000;
		auto_val   = 4'h0;

		repeat (RESET_CYC) begin
			@(negedge CLK);
			check_dark("in reset");
		end
		reset = 1'b0;
		@(negedge CLK);
		check_dark("after reset");
		capture_frame();
		compare_frame(exp_disp); // store clears to zero

		for (int r = 0; r < ROWS; r++) begin
			gap = $urandom % 2; // idle frames before the push
			repeat (gap * FRAME_CYC) @(negedge CLK);
			push_digit(PUSH_TABLE[r][19:16]);
			exp_disp = PUSH_TABLE[r][15:0];
			capture_frame();
			compare_frame(exp_disp);
		end

		// auto on just after a step, then push on the next one
		wait_step();
		@(negedge CLK);
		auto_mode = 1'b1;
		wait_step();
		push_digit(4'h7);
		exp_disp = {exp_disp[11:0], 4'h7}; // counter stays at 0
		capture_frame();
		compare_frame(exp_disp);

		for (int s = 0; s < AUTO_STEPS; s++) begin
			wait_step();
			@(negedge CLK);
			exp_disp = {exp_disp[11:0], auto_val};
			auto_val = auto_val + 4'h1; // wraps mod 16
			capture_frame();
			compare_frame(exp_disp);
		end
		auto_mode = 1'b0;

		$display("errors: %0d value, %0d scan", value_errs, scan_errs);
		if (value_errs + scan_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- seg_scroll.f
common/seg_pkg.sv
common/scan_if.sv
verilog/tick_gen.sv
scroll/digit_shift.sv
scan/digit_scan.sv
scan/seg_strobe.sv
verilog/seg_scroll_top.sv
test/seg_scroll_props.sv
test/seg_scroll_tb.sv

//--- Makefile
# Verilator build and run for the scrolling hex display driver

TOOL       = verilator
TOP        = seg_scroll_tb
FILELIST   = seg_scroll.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Testbench failed
PASS_MSG   = Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the run itself may stop early on an assertion
sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
